// ==== csr_pkg.sv ====
package csr_pkg;

    // ******************************
    // Basic CSR types
    // ******************************
    typedef logic [63:0] csr_data_t;    // CSR data word.
    typedef logic [11:0] csr_addr_t;    // CSR address.

    // Same codes as the low bits of funct3. Code 2'b00 is reserved.
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    // Supervisor CSRs held in this slice.
    localparam csr_addr_t CSR_SATP_ADDR     = 12'h180;
    localparam csr_addr_t CSR_SSCRATCH_ADDR = 12'h140;
    localparam csr_addr_t CSR_SEPC_ADDR     = 12'h141;
    localparam csr_addr_t CSR_STVAL_ADDR    = 12'h143;

    // ******************************
    // Buses between the blocks
    // ******************************
    typedef struct packed {
        logic      en;
        csr_op_e   op;
        csr_addr_t addr;
        csr_data_t operand;
    } csr_req_t;

    // New value is (old | sdata) & ~cdata.
    typedef struct packed {
        logic      wr;
        csr_addr_t waddr;
        csr_data_t sdata;
        csr_data_t cdata;
    } csr_wr_t;

    typedef struct packed {
        csr_data_t rdata;   // Zero when hit is low.
        logic      hit;
    } csr_rsp_t;

endpackage

// ==== mmu_pkg.sv ====
package mmu_pkg;

    // Machine XLEN code, as in misa.
    typedef logic [1:0] mxl_t;

    localparam mxl_t MXL_32 = 2'd1;     // Any other code selects RV64.

    // ******************************
    // Storage widths of the satp fields
    // ******************************
    localparam int SATP_PPN_W  = 44;
    localparam int SATP_ASID_W = 16;
    localparam int SATP_MODE_W = 4;

    // Field widths in the 32-bit layout.
    localparam int SATP32_PPN_W  = 22;
    localparam int SATP32_ASID_W = 9;
    localparam int SATP32_MODE_W = 1;

    // ******************************
    // Field positions
    // ******************************
    // 64-bit layout.
    localparam int SATP64_PPN_LSB  = 0;
    localparam int SATP64_ASID_LSB = 44;
    localparam int SATP64_MODE_LSB = 60;

    // 32-bit layout, zero extended to 64 bits on read.
    localparam int SATP32_PPN_LSB  = 0;
    localparam int SATP32_ASID_LSB = 22;
    localparam int SATP32_MODE_LSB = 31;

endpackage

// ==== csr_access_ctrl.sv ====
`timescale 1ns/1ps

module csr_access_ctrl (
    input  csr_pkg::csr_req_t req,
    output csr_pkg::csr_wr_t  wr_bus,
    input  csr_pkg::csr_rsp_t rsp_mmu,
    input  csr_pkg::csr_rsp_t rsp_trap,
    output csr_pkg::csr_rsp_t rsp,
    output logic              illegal
);

    logic               op_legal;
    logic               any_hit;
    csr_pkg::csr_data_t set_mask;
    csr_pkg::csr_data_t clr_mask;

    // ******************************
    // Operation to set/clear masks
    // ******************************
    always_comb begin
        op_legal = 1'b1;
        case (req.op)
            csr_pkg::CSR_RW: begin
                set_mask = req.operand;
                clr_mask = ~req.operand;     // Full overwrite.
            end
            csr_pkg::CSR_RS: begin
                set_mask = req.operand;
                clr_mask = '0;
            end
            csr_pkg::CSR_RC: begin
                set_mask = '0;
                clr_mask = req.operand;
            end
            default: begin
                set_mask = '0;
                clr_mask = '0;
                op_legal = 1'b0;             // Reserved code.
            end
        endcase
    end

    // ******************************
    // Response merge
    // ******************************
    // Blocks return zero data on a miss, so an OR is enough.
    assign any_hit = rsp_mmu.hit | rsp_trap.hit;

    assign rsp.rdata = rsp_mmu.rdata | rsp_trap.rdata;
    assign rsp.hit   = any_hit;

    assign illegal = req.en && (!any_hit || !op_legal);

    // Broadcast write, each block checks waddr on its own side.
    assign wr_bus.wr    = req.en && op_legal && any_hit;
    assign wr_bus.waddr = req.addr;
    assign wr_bus.sdata = set_mask;
    assign wr_bus.cdata = clr_mask;

endmodule

// ==== mmu_csr.sv ====
`timescale 1ns/1ps

module mmu_csr #(
    parameter int asid_bits = 16
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  mmu_pkg::mxl_t                   mxl,
    input  csr_pkg::csr_wr_t                wr_bus,
    input  csr_pkg::csr_addr_t              raddr,
    output csr_pkg::csr_rsp_t               rsp,
    output logic [mmu_pkg::SATP_PPN_W-1:0]  satp_ppn,
    output logic [mmu_pkg::SATP_ASID_W-1:0] satp_asid,
    output logic [mmu_pkg::SATP_MODE_W-1:0] satp_mode
);

    typedef logic [mmu_pkg::SATP_PPN_W-1:0]  ppn_t;
    typedef logic [mmu_pkg::SATP_ASID_W-1:0] asid_t;
    typedef logic [mmu_pkg::SATP_MODE_W-1:0] mode_t;

    // Mask of the implemented ASID bits.
    localparam asid_t asid_impl =
        asid_t'({mmu_pkg::SATP_ASID_W{1'b1}} >> (mmu_pkg::SATP_ASID_W - asid_bits));

    logic               is32;
    logic               satp_we;
    ppn_t               ppn_s, ppn_c, ppn_keep;
    asid_t              asid_s, asid_c, asid_keep;
    mode_t              mode_s, mode_c, mode_keep;
    csr_pkg::csr_data_t satp_rd;

    assign is32    = (mxl == mmu_pkg::MXL_32);
    assign satp_we = wr_bus.wr && (wr_bus.waddr == csr_pkg::CSR_SATP_ADDR);

    // ******************************
    // Field extraction for a write
    // ******************************
    always_comb begin
        if (is32) begin
            ppn_s  = ppn_t'(wr_bus.sdata[mmu_pkg::SATP32_PPN_LSB +: mmu_pkg::SATP32_PPN_W]);
            ppn_c  = ppn_t'(wr_bus.cdata[mmu_pkg::SATP32_PPN_LSB +: mmu_pkg::SATP32_PPN_W]);
            asid_s = asid_t'(wr_bus.sdata[mmu_pkg::SATP32_ASID_LSB +: mmu_pkg::SATP32_ASID_W]);
            asid_c = asid_t'(wr_bus.cdata[mmu_pkg::SATP32_ASID_LSB +: mmu_pkg::SATP32_ASID_W]);
            mode_s = mode_t'(wr_bus.sdata[mmu_pkg::SATP32_MODE_LSB +: mmu_pkg::SATP32_MODE_W]);
            mode_c = mode_t'(wr_bus.cdata[mmu_pkg::SATP32_MODE_LSB +: mmu_pkg::SATP32_MODE_W]);
            // Upper storage bits are dropped in RV32.
            ppn_keep  = ppn_t'({mmu_pkg::SATP32_PPN_W{1'b1}});
            asid_keep = asid_t'({mmu_pkg::SATP32_ASID_W{1'b1}});
            mode_keep = mode_t'({mmu_pkg::SATP32_MODE_W{1'b1}});
        end else begin
            ppn_s     = wr_bus.sdata[mmu_pkg::SATP64_PPN_LSB +: mmu_pkg::SATP_PPN_W];
            ppn_c     = wr_bus.cdata[mmu_pkg::SATP64_PPN_LSB +: mmu_pkg::SATP_PPN_W];
            asid_s    = wr_bus.sdata[mmu_pkg::SATP64_ASID_LSB +: mmu_pkg::SATP_ASID_W];
            asid_c    = wr_bus.cdata[mmu_pkg::SATP64_ASID_LSB +: mmu_pkg::SATP_ASID_W];
            mode_s    = wr_bus.sdata[mmu_pkg::SATP64_MODE_LSB +: mmu_pkg::SATP_MODE_W];
            mode_c    = wr_bus.cdata[mmu_pkg::SATP64_MODE_LSB +: mmu_pkg::SATP_MODE_W];
            ppn_keep  = '1;
            asid_keep = '1;
            mode_keep = '1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            satp_ppn  <= '0;
            satp_asid <= '0;
            satp_mode <= '0;
        end else if (satp_we) begin
            satp_ppn  <= (satp_ppn | ppn_s) & ~ppn_c & ppn_keep;
            satp_asid <= (satp_asid | asid_s) & ~asid_c & asid_keep & asid_impl;
            satp_mode <= (satp_mode | mode_s) & ~mode_c & mode_keep;
        end
    end

    // ******************************
    // Read-back in the selected layout
    // ******************************
    always_comb begin
        satp_rd = '0;
        if (is32) begin
            satp_rd[mmu_pkg::SATP32_PPN_LSB +: mmu_pkg::SATP32_PPN_W] =
                satp_ppn[0 +: mmu_pkg::SATP32_PPN_W];
            satp_rd[mmu_pkg::SATP32_ASID_LSB +: mmu_pkg::SATP32_ASID_W] =
                satp_asid[0 +: mmu_pkg::SATP32_ASID_W];
            satp_rd[mmu_pkg::SATP32_MODE_LSB +: mmu_pkg::SATP32_MODE_W] =
                satp_mode[0 +: mmu_pkg::SATP32_MODE_W];
        end else begin
            satp_rd[mmu_pkg::SATP64_PPN_LSB +: mmu_pkg::SATP_PPN_W]   = satp_ppn;
            satp_rd[mmu_pkg::SATP64_ASID_LSB +: mmu_pkg::SATP_ASID_W] = satp_asid;
            satp_rd[mmu_pkg::SATP64_MODE_LSB +: mmu_pkg::SATP_MODE_W] = satp_mode;
        end
    end

    assign rsp.hit   = (raddr == csr_pkg::CSR_SATP_ADDR);
    assign rsp.rdata = rsp.hit ? satp_rd : '0;

endmodule

// ==== sup_trap_csr.sv ====
`timescale 1ns/1ps

module sup_trap_csr (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_wr_t   wr_bus,
    input  csr_pkg::csr_addr_t raddr,
    output csr_pkg::csr_rsp_t  rsp
);

    // Instructions are 16-bit aligned, so sepc bit 0 stays zero.
    localparam csr_pkg::csr_data_t sepc_mask = ~64'h1;

    csr_pkg::csr_data_t sscratch;
    csr_pkg::csr_data_t sepc;
    csr_pkg::csr_data_t stval;
    logic               sscratch_we;
    logic               sepc_we;
    logic               stval_we;

    // Set/clear rule shared by all three registers.
    function automatic csr_pkg::csr_data_t set_clr(csr_pkg::csr_data_t old_val,
                                                   csr_pkg::csr_wr_t   w);
        return (old_val | w.sdata) & ~w.cdata;
    endfunction

    // ******************************
    // Write decode and registers
    // ******************************
    assign sscratch_we = wr_bus.wr && (wr_bus.waddr == csr_pkg::CSR_SSCRATCH_ADDR);
    assign sepc_we     = wr_bus.wr && (wr_bus.waddr == csr_pkg::CSR_SEPC_ADDR);
    assign stval_we    = wr_bus.wr && (wr_bus.waddr == csr_pkg::CSR_STVAL_ADDR);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sscratch <= '0;
            sepc     <= '0;
            stval    <= '0;
        end else begin
            if (sscratch_we)
                sscratch <= set_clr(sscratch, wr_bus);
            if (sepc_we)
                sepc <= set_clr(sepc, wr_bus) & sepc_mask;
            if (stval_we)
                stval <= set_clr(stval, wr_bus);
        end
    end

    // ******************************
    // Read-back
    // ******************************
    always_comb begin
        rsp.rdata = '0;
        rsp.hit   = 1'b1;
        case (raddr)
            csr_pkg::CSR_SSCRATCH_ADDR: rsp.rdata = sscratch;
            csr_pkg::CSR_SEPC_ADDR:     rsp.rdata = sepc;
            csr_pkg::CSR_STVAL_ADDR:    rsp.rdata = stval;
            default:                    rsp.hit   = 1'b0;   // Not ours.
        endcase
    end

endmodule

// ==== csr_subsys_top.sv ====
`timescale 1ns/1ps

module csr_subsys_top #(
    parameter int asid_bits = 12
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  mmu_pkg::mxl_t                   mxl,
    input  csr_pkg::csr_req_t               req,
    output csr_pkg::csr_rsp_t               rsp,
    output logic                            illegal,
    output logic [mmu_pkg::SATP_PPN_W-1:0]  satp_ppn,
    output logic [mmu_pkg::SATP_ASID_W-1:0] satp_asid,
    output logic [mmu_pkg::SATP_MODE_W-1:0] satp_mode
);

    csr_pkg::csr_wr_t  wr_bus;      // Broadcast write to both blocks.
    csr_pkg::csr_rsp_t rsp_mmu;
    csr_pkg::csr_rsp_t rsp_trap;

    csr_access_ctrl u_ctrl (
        .req      (req),
        .wr_bus   (wr_bus),
        .rsp_mmu  (rsp_mmu),
        .rsp_trap (rsp_trap),
        .rsp      (rsp),
        .illegal  (illegal)
    );

    // ******************************
    // CSR blocks
    // ******************************
    mmu_csr #(
        .asid_bits (asid_bits)
    ) u_mmu_csr (
        .clk       (clk),
        .rstn      (rstn),
        .mxl       (mxl),
        .wr_bus    (wr_bus),
        .raddr     (req.addr),
        .rsp       (rsp_mmu),
        .satp_ppn  (satp_ppn),
        .satp_asid (satp_asid),
        .satp_mode (satp_mode)
    );

    sup_trap_csr u_sup_trap_csr (
        .clk    (clk),
        .rstn   (rstn),
        .wr_bus (wr_bus),
        .raddr  (req.addr),
        .rsp    (rsp_trap)
    );

endmodule

// ==== csr_subsys_chk.sv ====
`timescale 1ns/1ps

module csr_subsys_chk #(
    parameter int asid_bits = 12
) (
    input logic              clk,
    input logic              rstn,
    input csr_pkg::csr_req_t req,
    input csr_pkg::csr_rsp_t rsp,
    input logic              illegal,
    input logic [15:0]       satp_asid,
    input logic [3:0]        satp_mode
);

    logic op_reserved;
    int   fail_count = 0;   // Failed assertions so far.

    assign op_reserved = !(req.op inside {csr_pkg::CSR_RW, csr_pkg::CSR_RS, csr_pkg::CSR_RC});

    // ******************************
    // Response rules
    // ******************************
    illegal_cause: assert property (@(posedge clk) disable iff (!rstn)
        illegal |-> (!rsp.hit || op_reserved))
        else begin
            $error("illegal raised for a legal op on a known address");
            fail_count++;
        end

    illegal_needs_en: assert property (@(posedge clk) disable iff (!rstn)
        illegal |-> req.en)
        else begin
            $error("illegal raised without a request");
            fail_count++;
        end

    // Unimplemented ASID bits.
    asid_upper_zero: assert property (@(posedge clk) disable iff (!rstn)
        (satp_asid >> asid_bits) == '0)
        else begin
            $error("satp_asid has a bit set above the implemented width");
            fail_count++;
        end

    mode_after_reset: assert property (@(posedge clk)
        $rose(rstn) |-> satp_mode == '0)
        else begin
            $error("satp_mode not zero after reset release");
            fail_count++;
        end

endmodule

// ==== tb_csr_subsys.sv ====
`timescale 1ns/1ps

module tb_csr_subsys;

    localparam int          period          = 100;
    localparam int          reset_cycles    = 10;
    localparam int          n_txn           = 400;
    localparam int          asid_bits       = 12;
    localparam int          watchdog_cycles = n_txn + reset_cycles + 50;
    localparam logic [31:0] lfsr_taps       = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1.
    localparam logic [15:0] asid_keep       = 16'((1 << asid_bits) - 1);

    logic                clk;
    logic                rstn;
    mmu_pkg::mxl_t       mxl;
    csr_pkg::csr_req_t   req;
    csr_pkg::csr_rsp_t   rsp;
    logic                illegal;
    logic [43:0]         satp_ppn;
    logic [15:0]         satp_asid;
    logic [3:0]          satp_mode;

    // Reference model of the four CSRs.
    logic [43:0]         m_ppn;
    logic [15:0]         m_asid;
    logic [3:0]          m_mode;
    logic [63:0]         m_sscratch;
    logic [63:0]         m_sepc;
    logic [63:0]         m_stval;

    logic [31:0]         lfsr_state = 32'd79;
    int                  err_count  = 0;

    csr_subsys_top #(
        .asid_bits (asid_bits)
    ) dut0 (
        .clk       (clk),
        .rstn      (rstn),
        .mxl       (mxl),
        .req       (req),
        .rsp       (rsp),
        .illegal   (illegal),
        .satp_ppn  (satp_ppn),
        .satp_asid (satp_asid),
        .satp_mode (satp_mode)
    );

    bind csr_subsys_top csr_subsys_chk #(.asid_bits(asid_bits)) u_chk (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req),
        .rsp       (rsp),
        .illegal   (illegal),
        .satp_asid (satp_asid),
        .satp_mode (satp_mode)
    );

    initial clk = 1'b0;
    always #(period / 2) clk = ~clk;

    // ******************************
    // Random source
    // ******************************
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ lfsr_taps;
        return s >> 1;
    endfunction

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);      // One step per bit.
        end
        return v;
    endfunction

    function automatic csr_pkg::csr_addr_t known_addr(logic [1:0] sel);
        case (sel)
            2'd0:    return 12'h180;
            2'd1:    return 12'h140;
            2'd2:    return 12'h141;
            default: return 12'h143;
        endcase
    endfunction

    function automatic logic is_known(csr_pkg::csr_addr_t a);
        return a == 12'h180 || a == 12'h140 || a == 12'h141 || a == 12'h143;
    endfunction

    // ******************************
    // Model
    // ******************************
    function automatic logic [63:0] read_model(csr_pkg::csr_addr_t a, logic mode32);
        logic [63:0] v;
        v = '0;
        case (a)
            12'h180: v = mode32 ? {32'h0, m_mode[0], m_asid[8:0], m_ppn[21:0]}
                                : {m_mode, m_asid, m_ppn};
            12'h140: v = m_sscratch;
            12'h141: v = m_sepc;
            12'h143: v = m_stval;
            default: v = '0;
        endcase
        return v;
    endfunction

    task automatic apply_write(csr_pkg::csr_addr_t a, logic mode32,
                               logic [63:0] s, logic [63:0] c);
        case (a)
            12'h180: begin
                if (mode32) begin                   // Upper field bits are lost.
                    m_ppn  = {22'h0, (m_ppn[21:0] | s[21:0]) & ~c[21:0]};
                    m_asid = {7'h0, (m_asid[8:0] | s[30:22]) & ~c[30:22]} & asid_keep;
                    m_mode = {3'h0, (m_mode[0] | s[31]) & ~c[31]};
                end else begin
                    m_ppn  = (m_ppn | s[43:0]) & ~c[43:0];
                    m_asid = ((m_asid | s[59:44]) & ~c[59:44]) & asid_keep;
                    m_mode = (m_mode | s[63:60]) & ~c[63:60];
                end
            end
            12'h140: m_sscratch = (m_sscratch | s) & ~c;
            12'h141: m_sepc     = ((m_sepc | s) & ~c) & ~64'h1;
            12'h143: m_stval    = (m_stval | s) & ~c;
            default: ;
        endcase
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_outputs();
        logic mode32;
        logic hit;
        logic op_ok;
        mode32 = (mxl == mmu_pkg::MXL_32);
        hit    = is_known(req.addr);
        op_ok  = req.op inside {csr_pkg::CSR_RW, csr_pkg::CSR_RS, csr_pkg::CSR_RC};
        check_value("rsp.rdata", rsp.rdata, hit ? read_model(req.addr, mode32) : 64'h0);
        check_value("rsp.hit", rsp.hit, hit);
        check_value("illegal", illegal, req.en && (!hit || !op_ok));
        check_value("satp_ppn", satp_ppn, m_ppn);
        check_value("satp_asid", satp_asid, m_asid);
        check_value("satp_mode", satp_mode, m_mode);
    endtask

    // ******************************
    // Stimulus
    // ******************************
    initial begin
        logic [63:0] s_mask;
        logic [63:0] c_mask;
        logic        op_ok;
        rstn       = 1'b0;
        mxl        = 2'd2;
        req        = '0;
        m_ppn      = '0;
        m_asid     = '0;
        m_mode     = '0;
        m_sscratch = '0;
        m_sepc     = '0;
        m_stval    = '0;
        repeat (reset_cycles) @(negedge clk);
        rstn = 1'b1;

        for (int i = 0; i < n_txn; i++) begin
            @(negedge clk);
            if (i < 4) begin                        // Read back every CSR after reset.
                req.en      = 1'b1;
                req.op      = csr_pkg::CSR_RS;
                req.operand = '0;
                req.addr    = known_addr(2'(i));
            end else begin
                req.en = (rand_bits(3) != 64'd0);
                req.op = csr_pkg::csr_op_e'(2'(rand_bits(2)));
                if (rand_bits(3) == 64'd0)
                    req.addr = 12'(rand_bits(12));
                else
                    req.addr = known_addr(2'(rand_bits(2)));
                req.operand = rand_bits(64);
                if (rand_bits(2) == 64'd0)
                    mxl = 2'(rand_bits(2));
            end
            #(period / 4);
            check_outputs();                        // Old value in the same cycle.

            op_ok = 1'b1;
            case (req.op)
                csr_pkg::CSR_RW: begin
                    s_mask = req.operand;
                    c_mask = ~req.operand;
                end
                csr_pkg::CSR_RS: begin
                    s_mask = req.operand;
                    c_mask = '0;
                end
                csr_pkg::CSR_RC: begin
                    s_mask = '0;
                    c_mask = req.operand;
                end
                default: begin
                    s_mask = '0;
                    c_mask = '0;
                    op_ok  = 1'b0;
                end
            endcase
            @(posedge clk);
            if (req.en && op_ok && is_known(req.addr))
                apply_write(req.addr, mxl == mmu_pkg::MXL_32, s_mask, c_mask);
        end

        @(negedge clk);
        req = '0;
        #(period / 4);
        check_outputs();

        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Any failed bound assertion ends the run.
    always @(dut0.u_chk.fail_count) begin
        if (dut0.u_chk.fail_count != 0) begin
            $display("ERRORS FOUND");
            $fatal(1, "An assertion in the bound checker failed");
        end
    end

    // Watchdog.
    initial begin
        #(watchdog_cycles * period);
        $display("Timeout: the test sequence did not finish in time");
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== list.f ====
csr_pkg.sv
mmu_pkg.sv
csr_access_ctrl.sv
mmu_csr.sv
sup_trap_csr.sv
csr_subsys_top.sv
csr_subsys_chk.sv
tb_csr_subsys.sv

// ==== Bender.yml ====
package:
  name: csr_subsys

sources:
  # Packages first, the design units use them by scoped names.
  - csr_pkg.sv
  - mmu_pkg.sv

  # Design.
  - csr_access_ctrl.sv
  - mmu_csr.sv
  - sup_trap_csr.sv
  - csr_subsys_top.sv

  # Verification.
  - target: test
    files:
      - csr_subsys_chk.sv
      - tb_csr_subsys.sv
